/* flist.f */
+incdir+design
design/exec_ops_pkg.sv
design/exec_data_pkg.sv
design/issue_dispatch.sv
design/alu_unit.sv
design/branch_unit.sv
design/cdb_arbiter.sv
design/exec_stage.sv
testbench/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the exec stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_exec_stage -o sim_exec_stage

# The simulator may exit non-zero on failure, the log decides
./obj_dir/sim_exec_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

/* testbench/tb_exec_stage.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module tb_exec_stage;
    import exec_ops_pkg::*;
    import exec_data_pkg::*;

    localparam int NTAG = 1 << `EXEC_ROB_IDX_LEN;
    localparam int TMO  = 300;                  // Cycles per wait loop

    logic clk_i = 1'b0;
    logic rst_n_i, flush_i, issue_valid_i, issue_ready_o;
    logic cdb_ready_i = 1'b1;
    logic cdb_valid_o;
    issue_req_t  issue_i;
    cdb_data_t   cdb_o;
    branch_res_t fetch_res_o;

    // ROB and fetch models
    integer seed = 75;
    integer bp_seed = 75;
    logic [`EXEC_XLEN-1:0] exp_val [NTAG];
    int iss_seq [NTAG];
    int done_seq [NTAG];
    branch_res_t fetch_exp [256];
    int fetch_wr, fetch_rd;
    rob_idx_t next_tag, last_tag;
    logic bp_mode, saw_full;
    int cyc, hold_until;
    string test_name;
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;
    logic prev_flush = 1'b0;
    cdb_data_t prev_data;

    exec_stage dut (.*);

    always #20 clk_i = ~clk_i;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_value(input string what, input logic [127:0] exp,
                                input logic [127:0] act);
        report_fail($sformatf("[ERROR] %s %s: expected %0h actual %0h",
                              test_name, what, exp, act));
    endtask

    function automatic logic busy(input rob_idx_t t);
        return iss_seq[t] != done_seq[t];
    endfunction

    // --------------------------------------------------
    // Reference models
    // --------------------------------------------------
    function automatic logic [31:0] ref_alu(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic branch_res_t ref_branch(input branch_op_t op, input logic [31:0] a,
            input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm,
            input logic pt, input logic [31:0] ptgt);
        branch_res_t r;
        logic [31:0] sum;
        sum = a + imm;
        r.valid = 1'b1;
        r.pc    = pc;
        case (op)
            BR_BEQ:  r.taken = (a == b);
            BR_BNE:  r.taken = (a != b);
            BR_BLT:  r.taken = ($signed(a) < $signed(b));
            BR_BGE:  r.taken = ($signed(a) >= $signed(b));
            default: r.taken = 1'b1;
        endcase
        if (op == BR_JALR) r.target = {sum[31:1], 1'b0};
        else r.target = r.taken ? pc + imm : pc + 32'd4;
        r.mispredict = (r.taken != pt) || (r.taken && (r.target != ptgt));
        return r;
    endfunction

    // --------------------------------------------------
    // Compare process sampling just before each rising edge
    // --------------------------------------------------
    always begin : compare
        rob_idx_t t;
        @(negedge clk_i);
        #19;
        if (rst_n_i) begin
            if (prev_valid && !prev_ready && !prev_flush) begin
                assert (cdb_valid_o && (cdb_o == prev_data)) else
                    report_fail("CDB output changed while the consumer was not ready");
            end
            if (cdb_valid_o && cdb_ready_i) begin
                t = cdb_o.rob_idx;
                assert (busy(t)) else
                    report_fail($sformatf("Broadcast of tag %0d that is not outstanding", t));
                assert (cdb_o.value == exp_val[t]) else
                    report_value($sformatf("cdb tag %0d", t), 128'(exp_val[t]),
                                 128'(cdb_o.value));
                done_seq[t] = iss_seq[t];
            end
            if (fetch_res_o.valid) begin
                assert (fetch_rd != fetch_wr) else
                    report_fail("Fetch result with no branch pending");
                assert (fetch_res_o == fetch_exp[fetch_rd % 256]) else
                    report_value("fetch result", 128'(fetch_exp[fetch_rd % 256]),
                                 128'(fetch_res_o));
                fetch_rd = fetch_rd + 1;
            end
            if (flush_i) begin                  // Everything in flight is cancelled
                for (int i = 0; i < NTAG; i++) done_seq[i] = iss_seq[i];
                fetch_rd = fetch_wr;
            end
        end
        prev_valid = cdb_valid_o;
        prev_ready = cdb_ready_i;
        prev_flush = flush_i;
        prev_data  = cdb_o;
    end

    // CDB consumer back-pressure
    always @(negedge clk_i) begin : consumer
        logic [31:0] r;
        cyc = cyc + 1;
        r = $random(bp_seed);
        if (cyc < hold_until) cdb_ready_i = 1'b0;
        else if (bp_mode) cdb_ready_i = r[0];
        else cdb_ready_i = 1'b1;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic make_operand(input logic dep, input rob_idx_t src,
                                output op_data_t op, output logic [31:0] val);
        val = $random(seed);
        if (dep && busy(src) && (($random(seed) & 3) != 0)) begin
            op  = '{ready: 1'b0, rob_idx: src, value: '0};  // Wait on producer
            val = exp_val[src];
        end else begin
            op = '{ready: 1'b1, rob_idx: rob_idx_t'($random(seed)), value: val};
        end
    endtask

    task automatic issue_one(input eu_sel_t eu, input alu_op_t aop, input branch_op_t bop,
                             input logic dep, input logic pred_ok);
        op_data_t op1, op2;
        logic [31:0] a, b;
        branch_res_t res;
        int cnt;
        cnt = 0;
        while (busy(next_tag)) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > TMO) report_fail("No free ROB tag before the timeout");
        end
        issue_i.eu = eu;
        #1;
        cnt = 0;
        while (!issue_ready_o) begin
            saw_full = 1'b1;
            @(negedge clk_i);
            #1;
            cnt++;
            if (cnt > TMO) report_fail("Issue was not accepted before the timeout");
        end
        make_operand(dep, last_tag, op1, a);
        make_operand(dep, last_tag - 4'd1, op2, b);
        if (eu == EU_BRANCH && op2.ready && (($random(seed) & 1) != 0)) begin
            b = a;                              // Equal operands for BEQ and BNE
            op2.value = a;
        end
        issue_i.alu_op    = aop;
        issue_i.branch_op = bop;
        issue_i.rs1       = op1;
        issue_i.rs2       = op2;
        issue_i.imm       = ($random(seed) % 2048) & ~32'd1;
        issue_i.curr_pc   = $random(seed) & 32'hffff_fffc;
        issue_i.rob_idx   = next_tag;
        if (eu == EU_ALU) begin
            exp_val[next_tag] = ref_alu(aop, a, b);
        end else begin
            res = ref_branch(bop, a, b, issue_i.curr_pc, issue_i.imm, 1'b0, '0);
            // A wrong jump prediction keeps the direction and misses the target
            issue_i.pred_taken  = (pred_ok || (bop == BR_JAL) || (bop == BR_JALR)) ?
                                  res.taken : !res.taken;
            issue_i.pred_target = (pred_ok && res.taken) ? res.target : res.target + 32'd8;
            fetch_exp[fetch_wr % 256] = ref_branch(bop, a, b, issue_i.curr_pc, issue_i.imm,
                                                   issue_i.pred_taken, issue_i.pred_target);
            fetch_wr = fetch_wr + 1;
            exp_val[next_tag] = issue_i.curr_pc + 32'd4;    // Link value
        end
        iss_seq[next_tag] = iss_seq[next_tag] + 1;
        last_tag = next_tag;
        next_tag++;
        issue_valid_i = 1'b1;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic issue_random(input logic dep);
        logic [31:0] r;
        r = $random(seed);
        issue_one(eu_sel_t'(r[3]), alu_op_t'(r[2:0]),
                  branch_op_t'(3'(r[31:4] % 6)), dep, r[8]);
    endtask

    task automatic wait_drain();
        int cnt;
        logic pending;
        cnt = 0;
        bp_mode = 1'b0;
        hold_until = 0;
        pending = 1'b1;
        while (pending) begin
            pending = 1'b0;
            for (int i = 0; i < NTAG; i++) pending |= busy(rob_idx_t'(i));
            if (pending) begin
                @(negedge clk_i);
                cnt++;
                if (cnt > TMO) report_fail("Outstanding instructions did not drain in time");
            end
        end
        assert (fetch_rd == fetch_wr) else report_fail("A fetch result never arrived");
    endtask

    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_i = '0;
        bp_mode = 1'b0;
        saw_full = 1'b0;
        next_tag = '0;
        last_tag = '0;
        hold_until = 0;
        test_name = "reset";
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (issue_ready_o && !cdb_valid_o && !fetch_res_o.valid) else
            report_fail("Outputs are not idle after reset");

        test_name = "alu_ready";
        for (int r = 0; r < 3; r++)
            for (int k = 0; k < 8; k++) issue_one(EU_ALU, alu_op_t'(k), BR_BEQ, 1'b0, 1'b1);
        wait_drain();

        test_name = "dep_chain";
        for (int i = 0; i < 40; i++) issue_one(EU_ALU, alu_op_t'(3'($random(seed))), BR_BEQ,
                                               1'b1, 1'b1);
        wait_drain();

        test_name = "branch";
        for (int r = 0; r < 2; r++)
            for (int k = 0; k < 6; k++)
                for (int p = 0; p < 2; p++) begin
                    if (r == 1) issue_one(EU_ALU, ALU_ADD, BR_BEQ, 1'b0, 1'b1);
                    issue_one(EU_BRANCH, ALU_ADD, branch_op_t'(k), r == 1, p == 1);
                end
        wait_drain();

        test_name = "backpressure";
        saw_full = 1'b0;
        hold_until = cyc + 20;                  // Fill the stations first
        bp_mode = 1'b1;
        for (int i = 0; i < 40; i++) issue_random(1'b1);
        assert (saw_full) else report_fail("Issue ready never fell with full stations");
        wait_drain();

        test_name = "flush";
        hold_until = cyc + 30;
        for (int i = 0; i < 4; i++) issue_random(1'b1);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        assert (!cdb_valid_o) else report_fail("CDB valid is still high after the flush");
        hold_until = 0;
        bp_mode = 1'b1;
        for (int i = 0; i < 20; i++) issue_random(1'b1);
        wait_drain();

        $display("Regression passed");
        $finish;
    end

endmodule

/* design/exec_stage.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_stage (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        issue_valid_i,
    input  exec_data_pkg::issue_req_t   issue_i,
    output logic                        issue_ready_o,
    input  logic                        cdb_ready_i,
    output logic                        cdb_valid_o,
    output exec_data_pkg::cdb_data_t    cdb_o,
    output exec_data_pkg::branch_res_t  fetch_res_o
);
    import exec_data_pkg::*;

    logic       alu_valid, alu_ready, bu_valid, bu_ready;
    issue_req_t disp_issue;     // Operands after CDB bypass
    logic       alu_req_valid, bu_req_valid, alu_grant, bu_grant;
    cdb_data_t  alu_req_data, bu_req_data;

    // ------------------------------------------------
    // Issue routing
    // ------------------------------------------------
    issue_dispatch u_issue_dispatch (
        .issue_valid_i (issue_valid_i), .issue_i (issue_i), .issue_ready_o (issue_ready_o),
        .alu_ready_i (alu_ready), .bu_ready_i (bu_ready), .alu_valid_o (alu_valid),
        .bu_valid_o (bu_valid), .issue_o (disp_issue), .cdb_valid_i (cdb_valid_o),
        .cdb_i (cdb_o)
    );

    // ------------------------------------------------
    // Execution units
    // ------------------------------------------------
    alu_unit #(.RS_DEPTH (`EXEC_ALU_RS_DEPTH)) u_alu_unit (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .issue_valid_i (alu_valid), .issue_i (disp_issue), .issue_ready_o (alu_ready),
        .cdb_valid_i (cdb_valid_o), .cdb_i (cdb_o), .grant_i (alu_grant),
        .req_valid_o (alu_req_valid), .req_data_o (alu_req_data)
    );

    branch_unit #(.RS_DEPTH (`EXEC_BU_RS_DEPTH)) u_branch_unit (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .issue_valid_i (bu_valid), .issue_i (disp_issue), .issue_ready_o (bu_ready),
        .cdb_valid_i (cdb_valid_o), .cdb_i (cdb_o), .grant_i (bu_grant),
        .req_valid_o (bu_req_valid), .req_data_o (bu_req_data), .fetch_res_o (fetch_res_o)
    );

    // ------------------------------------------------
    // CDB
    // ------------------------------------------------
    cdb_arbiter u_cdb_arbiter (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .bu_valid_i (bu_req_valid), .alu_valid_i (alu_req_valid),
        .bu_data_i (bu_req_data), .alu_data_i (alu_req_data),
        .bu_grant_o (bu_grant), .alu_grant_o (alu_grant),
        .cdb_ready_i (cdb_ready_i), .cdb_valid_o (cdb_valid_o), .cdb_o (cdb_o)
    );

endmodule

/* design/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Unit requests
    input  logic                        bu_valid_i,
    input  logic                        alu_valid_i,
    input  exec_data_pkg::cdb_data_t    bu_data_i,
    input  exec_data_pkg::cdb_data_t    alu_data_i,
    output logic                        bu_grant_o,
    output logic                        alu_grant_o,

    // Broadcast
    input  logic                        cdb_ready_i,
    output logic                        cdb_valid_o,
    output exec_data_pkg::cdb_data_t    cdb_o
);
    import exec_data_pkg::*;

    logic       cdb_valid_q;
    cdb_data_t  cdb_q;
    logic       load_ok;

    // ------------------------------------------------
    // Fixed priority grant
    // ------------------------------------------------

    // Register empty or draining on this edge
    assign load_ok     = (!cdb_valid_q || cdb_ready_i) && !flush_i;
    assign bu_grant_o  = load_ok && bu_valid_i;
    assign alu_grant_o = load_ok && alu_valid_i && !bu_valid_i;   // Branch wins

    // ------------------------------------------------
    // CDB output register
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_q <= 1'b0;
        end else if (flush_i) begin
            cdb_valid_q <= 1'b0;
        end else if (bu_grant_o || alu_grant_o) begin
            cdb_valid_q <= 1'b1;
        end else if (cdb_ready_i) begin
            cdb_valid_q <= 1'b0;            // Drained, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (bu_grant_o) begin
            cdb_q <= bu_data_i;
        end else if (alu_grant_o) begin
            cdb_q <= alu_data_i;
        end
    end

    assign cdb_valid_o = cdb_valid_q;
    assign cdb_o       = cdb_q;

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module branch_unit #(
    parameter int RS_DEPTH = `EXEC_BU_RS_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        issue_valid_i,
    input  exec_data_pkg::issue_req_t   issue_i,
    output logic                        issue_ready_o,
    input  logic                        cdb_valid_i,
    input  exec_data_pkg::cdb_data_t    cdb_i,
    input  logic                        grant_i,
    output logic                        req_valid_o,
    output exec_data_pkg::cdb_data_t    req_data_o,
    output exec_data_pkg::branch_res_t  fetch_res_o
);
    import exec_ops_pkg::*;
    import exec_data_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(RS_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    issue_req_t             fifo_q [RS_DEPTH];
    logic [IDX_W-1:0]       head_q, tail_q;
    logic [CNT_W-1:0]       count_q;
    issue_req_t             head;
    logic                   push, ops_ok, taken;
    logic [`EXEC_XLEN-1:0]  a, b, pc_plus4, target, jalr_sum;

    assign issue_ready_o = (count_q != CNT_W'(RS_DEPTH));   // Full drops ready
    assign push          = issue_valid_i && issue_ready_o;

    // ------------------------------------------------
    // FIFO control
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin         // Flush empties the station
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= ptr_inc(tail_q);
            if (grant_i) head_q <= ptr_inc(head_q);
            count_q <= count_q + CNT_W'(push) - CNT_W'(grant_i);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid_i && !fifo_q[i].rs1.ready && (fifo_q[i].rs1.rob_idx == cdb_i.rob_idx)) begin
                fifo_q[i].rs1 <= '{ready: 1'b1, rob_idx: cdb_i.rob_idx, value: cdb_i.value};
            end
            if (cdb_valid_i && !fifo_q[i].rs2.ready && (fifo_q[i].rs2.rob_idx == cdb_i.rob_idx)) begin
                fifo_q[i].rs2 <= '{ready: 1'b1, rob_idx: cdb_i.rob_idx, value: cdb_i.value};
            end
        end
        if (push) fifo_q[tail_q] <= issue_i;
    end

    // ------------------------------------------------
    // Resolution of the head entry
    // ------------------------------------------------
    assign head     = fifo_q[head_q];
    assign a        = head.rs1.value;
    assign b        = head.rs2.value;
    assign pc_plus4 = head.curr_pc + `EXEC_XLEN'(4);
    assign jalr_sum = a + head.imm;

    always_comb begin
        case (head.branch_op)
            BR_BEQ:  taken = (a == b);
            BR_BNE:  taken = (a != b);
            BR_BLT:  taken = ($signed(a) < $signed(b));
            BR_BGE:  taken = ($signed(a) >= $signed(b));
            default: taken = 1'b1;                  // Jumps
        endcase
        if (head.branch_op == BR_JALR) target = {jalr_sum[`EXEC_XLEN-1:1], 1'b0};
        else if (taken) target = head.curr_pc + head.imm;
        else target = pc_plus4;
        // JAL reads no operand and JALR only rs1
        ops_ok = (head.branch_op == BR_JAL) || (head.rs1.ready &&
                 (head.rs2.ready || (head.branch_op == BR_JALR)));
    end

    assign req_valid_o        = (count_q != '0) && ops_ok;
    assign req_data_o.rob_idx = head.rob_idx;
    assign req_data_o.value   = pc_plus4;           // Link value

    assign fetch_res_o.valid      = grant_i;
    assign fetch_res_o.pc         = head.curr_pc;
    assign fetch_res_o.target     = target;
    assign fetch_res_o.taken      = taken;
    assign fetch_res_o.mispredict = (taken != head.pred_taken) ||
                                    (taken && (target != head.pred_target));

endmodule

/* design/alu_unit.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module alu_unit #(
    parameter int RS_DEPTH = `EXEC_ALU_RS_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Issue
    input  logic                        issue_valid_i,
    input  exec_data_pkg::issue_req_t   issue_i,
    output logic                        issue_ready_o,

    // CDB snoop for wakeup
    input  logic                        cdb_valid_i,
    input  exec_data_pkg::cdb_data_t    cdb_i,

    // Arbiter request
    input  logic                        grant_i,
    output logic                        req_valid_o,
    output exec_data_pkg::cdb_data_t    req_data_o
);
    import exec_ops_pkg::*;
    import exec_data_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    typedef struct packed {
        alu_op_t    op;
        op_data_t   rs1;
        op_data_t   rs2;
        rob_idx_t   rob_idx;
    } alu_entry_t;

    logic [RS_DEPTH-1:0]    valid_q;
    alu_entry_t             rs_q [RS_DEPTH];
    logic [IDX_W-1:0]       free_idx;
    logic [IDX_W-1:0]       ex_idx;
    logic                   free_found;
    logic                   ex_found;
    logic                   issue_fire;
    logic [`EXEC_XLEN-1:0]  opa;
    logic [`EXEC_XLEN-1:0]  opb;
    logic [`EXEC_XLEN-1:0]  result;

    // ------------------------------------------------
    // Slot selection
    // ------------------------------------------------
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        ex_found   = 1'b0;
        ex_idx     = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!valid_q[i] && !free_found) begin     // Lowest free slot
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (valid_q[i] && rs_q[i].rs1.ready && rs_q[i].rs2.ready && !ex_found) begin
                ex_found = 1'b1;
                ex_idx   = IDX_W'(i);
            end
        end
    end

    assign issue_ready_o = free_found;
    assign issue_fire    = issue_valid_i && free_found;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            if (grant_i) valid_q[ex_idx] <= 1'b0;         // Retire on grant
            if (issue_fire) valid_q[free_idx] <= 1'b1;
        end
    end

    // Wakeup first, a new entry overrides its own slot
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid_i && !rs_q[i].rs1.ready && (rs_q[i].rs1.rob_idx == cdb_i.rob_idx)) begin
                rs_q[i].rs1.ready <= 1'b1;
                rs_q[i].rs1.value <= cdb_i.value;
            end
            if (cdb_valid_i && !rs_q[i].rs2.ready && (rs_q[i].rs2.rob_idx == cdb_i.rob_idx)) begin
                rs_q[i].rs2.ready <= 1'b1;
                rs_q[i].rs2.value <= cdb_i.value;
            end
        end
        if (issue_fire) begin
            rs_q[free_idx] <= '{op: issue_i.alu_op, rs1: issue_i.rs1, rs2: issue_i.rs2,
                                rob_idx: issue_i.rob_idx};
        end
    end

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------
    assign opa = rs_q[ex_idx].rs1.value;
    assign opb = rs_q[ex_idx].rs2.value;

    always_comb begin
        case (rs_q[ex_idx].op)
            ALU_ADD: result = opa + opb;
            ALU_SUB: result = opa - opb;
            ALU_AND: result = opa & opb;
            ALU_OR:  result = opa | opb;
            ALU_XOR: result = opa ^ opb;
            ALU_SLL: result = opa << opb[4:0];
            ALU_SRL: result = opa >> opb[4:0];
            ALU_SLT: result = {{(`EXEC_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            default: result = '0;
        endcase
    end

    assign req_valid_o        = ex_found;
    assign req_data_o.rob_idx = rs_q[ex_idx].rob_idx;
    assign req_data_o.value   = result;

endmodule

/* design/issue_dispatch.sv */
`timescale 1ns/1ps

module issue_dispatch (
    // Issue stage side
    input  logic                        issue_valid_i,
    input  exec_data_pkg::issue_req_t   issue_i,
    output logic                        issue_ready_o,

    // Reservation stations
    input  logic                        alu_ready_i,
    input  logic                        bu_ready_i,
    output logic                        alu_valid_o,
    output logic                        bu_valid_o,
    output exec_data_pkg::issue_req_t   issue_o,

    // CDB snoop
    input  logic                        cdb_valid_i,
    input  exec_data_pkg::cdb_data_t    cdb_i
);
    import exec_ops_pkg::*;
    import exec_data_pkg::*;

    // A station cannot see a broadcast on the edge the entry is written,
    // so a matching tag is resolved here instead
    function automatic op_data_t bypass_op(input op_data_t op, input logic valid,
                                           input cdb_data_t cdb);
        op_data_t res;
        res = op;
        if (!op.ready && valid && (op.rob_idx == cdb.rob_idx)) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

    assign alu_valid_o   = issue_valid_i && (issue_i.eu == EU_ALU);
    assign bu_valid_o    = issue_valid_i && (issue_i.eu == EU_BRANCH);
    assign issue_ready_o = (issue_i.eu == EU_ALU) ? alu_ready_i : bu_ready_i;

    always_comb begin
        issue_o     = issue_i;
        issue_o.rs1 = bypass_op(issue_i.rs1, cdb_valid_i, cdb_i);
        issue_o.rs2 = bypass_op(issue_i.rs2, cdb_valid_i, cdb_i);
    end

endmodule

/* design/exec_data_pkg.sv */
`include "exec_consts.svh"

package exec_data_pkg;

    typedef logic [`EXEC_ROB_IDX_LEN-1:0] rob_idx_t;

    // One source operand, value valid only when ready is set
    typedef struct packed {
        logic                   ready;
        rob_idx_t               rob_idx;    // Producer tag while waiting
        logic [`EXEC_XLEN-1:0]  value;
    } op_data_t;

    typedef struct packed {
        exec_ops_pkg::eu_sel_t      eu;
        exec_ops_pkg::alu_op_t      alu_op;
        exec_ops_pkg::branch_op_t   branch_op;
        op_data_t                   rs1;
        op_data_t                   rs2;
        logic [`EXEC_XLEN-1:0]      imm;
        rob_idx_t                   rob_idx;        // Destination tag
        logic [`EXEC_XLEN-1:0]      curr_pc;
        logic [`EXEC_XLEN-1:0]      pred_target;
        logic                       pred_taken;
    } issue_req_t;

    typedef struct packed {
        rob_idx_t               rob_idx;
        logic [`EXEC_XLEN-1:0]  value;
    } cdb_data_t;

    typedef struct packed {
        logic                   valid;
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  target;     // Resolved next PC
        logic                   taken;
        logic                   mispredict;
    } branch_res_t;

endpackage

/* design/exec_ops_pkg.sv */
package exec_ops_pkg;

    // ------------------------------------------------
    // Integer ALU operations
    // ------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT     // Signed compare
    } alu_op_t;

    // ------------------------------------------------
    // Branch unit operations
    // ------------------------------------------------
    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,     // Signed
        BR_BGE,     // Signed
        BR_JAL,
        BR_JALR
    } branch_op_t;

    // Target execution unit of an issued instruction
    typedef enum logic {
        EU_ALU,
        EU_BRANCH
    } eu_sel_t;

endpackage

/* design/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ------------------------------------------------
// Datapath widths
// ------------------------------------------------

// Data and address width
`define EXEC_XLEN 32

// ROB tag width, 16 entries in flight
`define EXEC_ROB_IDX_LEN 4

// ------------------------------------------------
// Reservation stations
// ------------------------------------------------

// Integer ALU, out-of-order pick
`define EXEC_ALU_RS_DEPTH 4

// Branch unit, in-order FIFO
`define EXEC_BU_RS_DEPTH 2

`endif
